// ==== la32_pipe.f ====
design/la32_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/reg_file.sv
design/exec_stage.sv
design/wb_stage.sv
design/la32_pipe_top.sv
sim/la32_pipe_tb.sv

// ==== Bender.yml ====
package:
  name: la32_pipe

sources:
  - files:
      - design/la32_pkg.sv
      - design/fetch_stage.sv
      - design/decode_stage.sv
      - design/reg_file.sv
      - design/exec_stage.sv
      - design/wb_stage.sv
      - design/la32_pipe_top.sv

  - target: simulation
    files:
      - sim/la32_pipe_tb.sv

// ==== sim/la32_pipe_tb.sv ====
// ======================================================================
// la32 pipe testbench: inst SRAM responder, trace checker, watchdog
// ======================================================================
`timescale 1ns/10ps

module la32_pipe_tb;

    localparam int              CLK_PERIOD    = 40;
    localparam logic [31:0]     RESET_PC      = 32'h1c00_0000;
    localparam int              PROG_LEN      = 24;
    localparam int              EXP_LEN       = 13;
    localparam int              NUM_PASSES    = 2;
    localparam int              SETTLE_CYCLES = 20;
    localparam int              WATCHDOG_CYCLES =
        NUM_PASSES * (EXP_LEN * 8 + 50 + SETTLE_CYCLES + 4);
    localparam logic [16:0]     OP_ADD_W = 17'h00020;
    localparam logic [16:0]     OP_SUB_W = 17'h00022;
    localparam logic [16:0]     OP_AND   = 17'h00029;
    localparam logic [16:0]     OP_OR    = 17'h0002a;
    localparam logic [16:0]     OP_XOR   = 17'h0002b;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  wnum;
        logic [31:0] wdata;
    } trace_t;

    logic        clk;
    logic        rst_n_i;
    logic        inst_sram_req_o;
    logic [31:0] inst_sram_addr_o;
    logic        inst_sram_addr_ok_i;
    logic        inst_sram_data_ok_i;
    logic [31:0] inst_sram_rdata_i;
    logic [31:0] debug_wb_pc_o;
    logic [3:0]  debug_wb_rf_we_o;
    logic [4:0]  debug_wb_rf_wnum_o;
    logic [31:0] debug_wb_rf_wdata_o;

    logic [31:0] prog_mem [PROG_LEN];
    trace_t      exp_trace [EXP_LEN];
    int          trace_idx;
    int          checks;
    int          errors;
    int          pass;
    logic        random_delays;
    logic [31:0] lfsr_state;

    // responder state, one request in flight at most
    logic        snap_rst;
    logic        snap_req;
    logic [31:0] snap_addr;
    logic        waiting;
    logic [31:0] wait_addr;
    logic        outstanding;
    logic [31:0] resp_addr;
    logic [31:0] word_offset;
    logic [1:0]  addr_wait;
    logic [1:0]  data_wait;

    la32_pipe_top #(
        .RESET_PC (RESET_PC)
    ) uut (
        .clk                 (clk),
        .rst_n_i             (rst_n_i),
        .inst_sram_req_o     (inst_sram_req_o),
        .inst_sram_addr_o    (inst_sram_addr_o),
        .inst_sram_addr_ok_i (inst_sram_addr_ok_i),
        .inst_sram_data_ok_i (inst_sram_data_ok_i),
        .inst_sram_rdata_i   (inst_sram_rdata_i),
        .debug_wb_pc_o       (debug_wb_pc_o),
        .debug_wb_rf_we_o    (debug_wb_rf_we_o),
        .debug_wb_rf_wnum_o  (debug_wb_rf_wnum_o),
        .debug_wb_rf_wdata_o (debug_wb_rf_wdata_o)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] enc_3r(input logic [16:0] op, input logic [4:0] rd,
                                           input logic [4:0] rj, input logic [4:0] rk);
        return {op, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rj,
                                             input logic [11:0] si12);
        return {10'h00a, si12, rj, rd};
    endfunction

    function automatic logic [31:0] enc_lu12i(input logic [4:0] rd, input logic [19:0] si20);
        return {7'h0a, si20, rd};
    endfunction

    function automatic logic [31:0] enc_bne(input logic [4:0] rj, input logic [4:0] rd,
                                            input logic [15:0] offs);
        return {6'h17, offs, rj, rd};
    endfunction

    // unknown opcode 6'h3f, retires as a no-op
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {6'h3f, addr[27:2] ^ {18'h0, addr[31:26], addr[1:0]}};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic draw_delay(output logic [1:0] d);
        d = 2'd0;
        if (random_delays) begin
            repeat (2) begin
                lfsr_state = lfsr_step(lfsr_state);
                d = {d[0], lfsr_state[0]};
            end
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < PROG_LEN; i++) begin
            prog_mem[i] = fill_word(RESET_PC + 32'(i * 4));
        end
        prog_mem[0]  = enc_lu12i(5'd1, 20'h12345);
        prog_mem[1]  = enc_addi(5'd1, 5'd1, 12'h678);
        prog_mem[2]  = enc_addi(5'd2, 5'd0, 12'hfff);
        prog_mem[3]  = enc_3r(OP_ADD_W, 5'd3, 5'd1, 5'd2);
        prog_mem[4]  = enc_3r(OP_SUB_W, 5'd4, 5'd3, 5'd1);
        prog_mem[5]  = enc_3r(OP_AND, 5'd5, 5'd3, 5'd1);
        prog_mem[6]  = enc_3r(OP_OR, 5'd6, 5'd1, 5'd3);
        prog_mem[7]  = enc_3r(OP_XOR, 5'd7, 5'd6, 5'd1);
        // write to r0 is dropped, r0 still reads zero
        prog_mem[8]  = enc_addi(5'd0, 5'd1, 12'h005);
        prog_mem[9]  = enc_3r(OP_ADD_W, 5'd8, 5'd0, 5'd7);
        prog_mem[10] = enc_bne(5'd8, 5'd7, 16'd2);
        prog_mem[11] = enc_addi(5'd9, 5'd0, 12'h010);
        prog_mem[12] = enc_bne(5'd9, 5'd8, 16'd3);
        prog_mem[13] = enc_addi(5'd10, 5'd0, 12'h001);
        prog_mem[14] = enc_addi(5'd11, 5'd0, 12'h002);
        prog_mem[15] = enc_addi(5'd12, 5'd9, 12'h7ff);
        prog_mem[16] = enc_3r(OP_SUB_W, 5'd13, 5'd12, 5'd9);
        prog_mem[17] = enc_3r(OP_ADD_W, 5'd14, 5'd13, 5'd13);
        // spin on a taken bne to itself
        prog_mem[18] = enc_bne(5'd1, 5'd0, 16'd0);

        exp_trace[0]  = {32'h1c00_0000, 5'd1,  32'h1234_5000};
        exp_trace[1]  = {32'h1c00_0004, 5'd1,  32'h1234_5678};
        exp_trace[2]  = {32'h1c00_0008, 5'd2,  32'hffff_ffff};
        exp_trace[3]  = {32'h1c00_000c, 5'd3,  32'h1234_5677};
        exp_trace[4]  = {32'h1c00_0010, 5'd4,  32'hffff_ffff};
        exp_trace[5]  = {32'h1c00_0014, 5'd5,  32'h1234_5670};
        exp_trace[6]  = {32'h1c00_0018, 5'd6,  32'h1234_567f};
        exp_trace[7]  = {32'h1c00_001c, 5'd7,  32'h0000_0007};
        exp_trace[8]  = {32'h1c00_0024, 5'd8,  32'h0000_0007};
        exp_trace[9]  = {32'h1c00_002c, 5'd9,  32'h0000_0010};
        exp_trace[10] = {32'h1c00_003c, 5'd12, 32'h0000_080f};
        exp_trace[11] = {32'h1c00_0040, 5'd13, 32'h0000_07ff};
        exp_trace[12] = {32'h1c00_0044, 5'd14, 32'h0000_0ffe};
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #2;
        rst_n_i   = 1'b0;
        trace_idx = 0;
        @(negedge clk);
        check_value("debug_wb_rf_we_o", debug_wb_rf_we_o, 32'h0);
        repeat (2) @(posedge clk);
        #2;
        rst_n_i = 1'b1;
        #1;
        check_value("inst_sram_req_o", inst_sram_req_o, 32'h1);
        check_value("inst_sram_addr_o", inst_sram_addr_o, RESET_PC);
        check_value("debug_wb_rf_we_o", debug_wb_rf_we_o, 32'h0);
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // sample at the falling edge, drive 2 ns after the rising edge
    initial begin : sram_responder
        forever begin
            @(negedge clk);
            snap_rst  = rst_n_i;
            snap_req  = inst_sram_req_o;
            snap_addr = inst_sram_addr_o;
            @(posedge clk);
            #2;
            if (!snap_rst) begin
                waiting     = 1'b0;
                outstanding = 1'b0;
                draw_delay(addr_wait);
                inst_sram_data_ok_i = 1'b0;
            end else begin
                if (waiting) begin
                    check_value("inst_sram_req_o", snap_req, 32'h1);
                    check_value("inst_sram_addr_o", snap_addr, wait_addr);
                end
                if (inst_sram_data_ok_i) begin
                    outstanding = 1'b0;
                end
                waiting   = snap_req && !inst_sram_addr_ok_i;
                wait_addr = snap_addr;
                if (snap_req && inst_sram_addr_ok_i) begin
                    if (outstanding) begin
                        errors++;
                        $display("Second fetch request accepted while one was outstanding");
                    end
                    outstanding = 1'b1;
                    resp_addr   = snap_addr;
                    draw_delay(data_wait);
                    draw_delay(addr_wait);
                end else if (snap_req && addr_wait != 2'd0) begin
                    addr_wait = addr_wait - 2'd1;
                end
                if (outstanding && data_wait == 2'd0) begin
                    word_offset = resp_addr - RESET_PC;
                    if (resp_addr >= RESET_PC && word_offset < PROG_LEN * 4) begin
                        inst_sram_rdata_i = prog_mem[word_offset >> 2];
                    end else begin
                        errors++;
                        $display("Fetch left the program at address %h", resp_addr);
                        inst_sram_rdata_i = fill_word(resp_addr);
                    end
                    inst_sram_data_ok_i = 1'b1;
                end else begin
                    inst_sram_data_ok_i = 1'b0;
                    if (outstanding) begin
                        data_wait = data_wait - 2'd1;
                    end
                end
            end
            inst_sram_addr_ok_i = (addr_wait == 2'd0);
        end
    end

    initial begin : trace_monitor
        forever begin
            @(negedge clk);
            if (rst_n_i && debug_wb_rf_we_o != 4'h0) begin
                if (trace_idx < EXP_LEN) begin
                    check_value("debug_wb_rf_we_o", debug_wb_rf_we_o, 32'hf);
                    check_value("debug_wb_pc_o", debug_wb_pc_o, exp_trace[trace_idx].pc);
                    check_value("debug_wb_rf_wnum_o", debug_wb_rf_wnum_o,
                                exp_trace[trace_idx].wnum);
                    check_value("debug_wb_rf_wdata_o", debug_wb_rf_wdata_o,
                                exp_trace[trace_idx].wdata);
                end else begin
                    errors++;
                    $display("Unexpected write to r%0d at pc %h after the last expected entry",
                             debug_wb_rf_wnum_o, debug_wb_pc_o);
                end
                trace_idx++;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        errors++;
        $display("Timeout: the write-back trace stalled at entry %0d of %0d in pass %0d",
                 trace_idx, EXP_LEN, pass);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        rst_n_i             = 1'b0;
        inst_sram_addr_ok_i = 1'b0;
        inst_sram_data_ok_i = 1'b0;
        inst_sram_rdata_i   = 32'h0;
        trace_idx           = 0;
        checks              = 0;
        errors              = 0;
        random_delays       = 1'b0;
        lfsr_state          = 32'h478a_f60d;
        load_program();
        // pass 0 without SRAM delays, pass 1 with random delays
        for (pass = 0; pass < NUM_PASSES; pass++) begin
            random_delays = (pass != 0);
            apply_reset();
            wait (trace_idx >= EXP_LEN);
            repeat (SETTLE_CYCLES) @(posedge clk);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== design/la32_pipe_top.sv ====
// ======================================================================
// la32 four-stage pipe: fetch, decode, execute, write-back
// ======================================================================
`timescale 1ns/10ps

module la32_pipe_top import la32_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = la32_pkg::RESET_PC
) (
    input  logic                  clk,
    input  logic                  rst_n_i,
    output logic                  inst_sram_req_o,
    output logic [XLEN-1:0]       inst_sram_addr_o,
    input  logic                  inst_sram_addr_ok_i,
    input  logic                  inst_sram_data_ok_i,
    input  logic [XLEN-1:0]       inst_sram_rdata_i,
    output logic [XLEN-1:0]       debug_wb_pc_o,
    output logic [3:0]            debug_wb_rf_we_o,
    output logic [REG_ADDR_W-1:0] debug_wb_rf_wnum_o,
    output logic [XLEN-1:0]       debug_wb_rf_wdata_o
);

    logic                  if_valid;
    if_to_id_t             if_to_id;
    logic                  id_allowin;
    logic                  id_valid;
    id_to_ex_t             id_to_ex;
    logic [REG_ADDR_W-1:0] rj_addr;
    logic [REG_ADDR_W-1:0] rk_addr;
    logic [XLEN-1:0]       rj_data;
    logic [XLEN-1:0]       rk_data;
    logic                  ex_allowin;
    logic                  ex_valid;
    ex_to_wb_t             ex_to_wb;
    fwd_t                  ex_fwd;
    fwd_t                  wb_fwd;
    redirect_t             redirect;
    wb_write_t             wb_write;

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk                 (clk),
        .rst_n_i             (rst_n_i),
        .inst_sram_req_o     (inst_sram_req_o),
        .inst_sram_addr_o    (inst_sram_addr_o),
        .inst_sram_addr_ok_i (inst_sram_addr_ok_i),
        .inst_sram_data_ok_i (inst_sram_data_ok_i),
        .inst_sram_rdata_i   (inst_sram_rdata_i),
        .id_allowin_i        (id_allowin),
        .redirect_i          (redirect),
        .if_valid_o          (if_valid),
        .if_to_id_o          (if_to_id)
    );

    // a taken branch also kills the instruction in decode
    decode_stage u_decode (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .if_valid_i   (if_valid),
        .if_to_id_i   (if_to_id),
        .id_allowin_o (id_allowin),
        .ex_allowin_i (ex_allowin),
        .flush_i      (redirect.taken),
        .ex_fwd_i     (ex_fwd),
        .wb_fwd_i     (wb_fwd),
        .rj_addr_o    (rj_addr),
        .rk_addr_o    (rk_addr),
        .rj_data_i    (rj_data),
        .rk_data_i    (rk_data),
        .id_valid_o   (id_valid),
        .id_to_ex_o   (id_to_ex)
    );

    reg_file u_rf (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .wb_write_i (wb_write),
        .rj_addr_i  (rj_addr),
        .rk_addr_i  (rk_addr),
        .rj_data_o  (rj_data),
        .rk_data_o  (rk_data)
    );

    exec_stage u_exec (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .id_valid_i   (id_valid),
        .id_to_ex_i   (id_to_ex),
        .ex_allowin_o (ex_allowin),
        .ex_valid_o   (ex_valid),
        .ex_to_wb_o   (ex_to_wb),
        .ex_fwd_o     (ex_fwd),
        .redirect_o   (redirect)
    );

    // write-back allowin is constant high, execute does not need it
    wb_stage u_wb (
        .clk                 (clk),
        .rst_n_i             (rst_n_i),
        .ex_valid_i          (ex_valid),
        .ex_to_wb_i          (ex_to_wb),
        .wb_allowin_o        (),
        .wb_write_o          (wb_write),
        .wb_fwd_o            (wb_fwd),
        .debug_wb_pc_o       (debug_wb_pc_o),
        .debug_wb_rf_we_o    (debug_wb_rf_we_o),
        .debug_wb_rf_wnum_o  (debug_wb_rf_wnum_o),
        .debug_wb_rf_wdata_o (debug_wb_rf_wdata_o)
    );

endmodule

// ==== design/wb_stage.sv ====
// ======================================================================
// write-back stage: register file update and debug trace
// ======================================================================
`timescale 1ns/10ps

module wb_stage import la32_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  ex_valid_i,
    input  ex_to_wb_t             ex_to_wb_i,
    output logic                  wb_allowin_o,
    output wb_write_t             wb_write_o,
    output fwd_t                  wb_fwd_o,
    output logic [XLEN-1:0]       debug_wb_pc_o,
    output logic [3:0]            debug_wb_rf_we_o,
    output logic [REG_ADDR_W-1:0] debug_wb_rf_wnum_o,
    output logic [XLEN-1:0]       debug_wb_rf_wdata_o
);

    logic      wb_valid_q;
    ex_to_wb_t wb_q;
    logic      we;

    // last stage, nothing downstream to wait on
    assign wb_allowin_o = 1'b1;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_valid_q <= 1'b0;
        end else begin
            wb_valid_q <= ex_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid_i) begin
            wb_q <= ex_to_wb_i;
        end
    end

    assign we         = wb_valid_q & wb_q.rf_we;
    assign wb_write_o = '{we: we, waddr: wb_q.rd, wdata: wb_q.result};
    assign wb_fwd_o   = '{valid: wb_valid_q, rf_we: wb_q.rf_we, rd: wb_q.rd, value: wb_q.result};

    // trace pc only shown with a write
    assign debug_wb_pc_o       = we ? wb_q.pc : '0;
    assign debug_wb_rf_we_o    = {4{we}};
    assign debug_wb_rf_wnum_o  = wb_q.rd;
    assign debug_wb_rf_wdata_o = wb_q.result;

endmodule

// ==== design/exec_stage.sv ====
// ======================================================================
// execute stage with the ALU, bne resolution and pc redirect to fetch
// ======================================================================
`timescale 1ns/10ps

module exec_stage import la32_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      id_valid_i,
    input  id_to_ex_t id_to_ex_i,
    output logic      ex_allowin_o,
    output logic      ex_valid_o,
    output ex_to_wb_t ex_to_wb_o,
    output fwd_t      ex_fwd_o,
    output redirect_t redirect_o
);

    logic            ex_valid_q;
    id_to_ex_t       ex_q;
    logic [XLEN-1:0] result;

    // execute always drains since write-back never stalls
    assign ex_allowin_o = 1'b1;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_valid_q <= 1'b0;
        end else begin
            ex_valid_q <= id_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (id_valid_i) begin
            ex_q <= id_to_ex_i;
        end
    end

    always_comb begin
        case (ex_q.alu_op)
            ALU_ADD: result = ex_q.src_a + ex_q.src_b;
            ALU_SUB: result = ex_q.src_a - ex_q.src_b;
            ALU_AND: result = ex_q.src_a & ex_q.src_b;
            ALU_OR:  result = ex_q.src_a | ex_q.src_b;
            ALU_XOR: result = ex_q.src_a ^ ex_q.src_b;
            ALU_LUI: result = ex_q.src_b;
            default: result = '0;
        endcase
    end

    // target = pc + sext(offs16 << 2)
    assign redirect_o.taken  = ex_valid_q & ex_q.is_bne & (ex_q.rj_val != ex_q.rd_val);
    assign redirect_o.target = ex_q.pc + {{14{ex_q.br_offs[15]}}, ex_q.br_offs, 2'b00};

    assign ex_valid_o = ex_valid_q;
    assign ex_to_wb_o = '{pc: ex_q.pc, rd: ex_q.rd, rf_we: ex_q.rf_we, result: result};
    assign ex_fwd_o   = '{valid: ex_valid_q, rf_we: ex_q.rf_we, rd: ex_q.rd, value: result};

    // the flushed decode slot leaves a bubble behind a taken bne
    a_redirect_valid: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        redirect_o.taken |-> ex_valid_o ##1 !ex_valid_o
    );

endmodule

// ==== design/reg_file.sv ====
// ======================================================================
// register file: 32 x 32, two combinational reads, r0 hardwired to zero
// ======================================================================
`timescale 1ns/10ps

module reg_file import la32_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  wb_write_t             wb_write_i,
    input  logic [REG_ADDR_W-1:0] rj_addr_i,
    input  logic [REG_ADDR_W-1:0] rk_addr_i,
    output logic [XLEN-1:0]       rj_data_o,
    output logic [XLEN-1:0]       rk_data_o
);

    // r1..r31 only
    logic [XLEN-1:0] regs_q [1:31];

    always_ff @(posedge clk) begin
        if (wb_write_i.we && wb_write_i.waddr != '0) begin
            regs_q[wb_write_i.waddr] <= wb_write_i.wdata;
        end
    end

    assign rj_data_o = (rj_addr_i == '0) ? '0 : regs_q[rj_addr_i];
    assign rk_data_o = (rk_addr_i == '0) ? '0 : regs_q[rk_addr_i];

    // decode already strips rf_we for rd == r0
    a_no_r0_write: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        wb_write_i.we |-> (wb_write_i.waddr != '0)
    );

endmodule

// ==== design/decode_stage.sv ====
// ======================================================================
// decode stage with instruction decode, register read and forwarding
// ======================================================================
`timescale 1ns/10ps

module decode_stage import la32_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  if_valid_i,
    input  if_to_id_t             if_to_id_i,
    output logic                  id_allowin_o,
    input  logic                  ex_allowin_i,
    input  logic                  flush_i,
    input  fwd_t                  ex_fwd_i,
    input  fwd_t                  wb_fwd_i,
    output logic [REG_ADDR_W-1:0] rj_addr_o,
    output logic [REG_ADDR_W-1:0] rk_addr_o,
    input  logic [XLEN-1:0]       rj_data_i,
    input  logic [XLEN-1:0]       rk_data_i,
    output logic                  id_valid_o,
    output id_to_ex_t             id_to_ex_o
);

    logic                  id_valid_q;
    if_to_id_t             id_q;
    logic [XLEN-1:0]       inst;
    logic [REG_ADDR_W-1:0] rd;
    alu_op_e               alu_op;
    logic [XLEN-1:0]       imm;
    logic                  use_imm;
    logic                  is_bne;
    logic [XLEN-1:0]       rj_val;
    logic [XLEN-1:0]       rk_val;

    // execute has priority over write-back and write-back over the RF
    function automatic logic [XLEN-1:0] pick_src(input logic [REG_ADDR_W-1:0] addr,
                                                 input logic [XLEN-1:0] rf_val,
                                                 input fwd_t ex_fwd,
                                                 input fwd_t wb_fwd);
        if (addr == '0) begin
            return '0;
        end
        if (ex_fwd.valid && ex_fwd.rf_we && ex_fwd.rd == addr) begin
            return ex_fwd.value;
        end
        if (wb_fwd.valid && wb_fwd.rf_we && wb_fwd.rd == addr) begin
            return wb_fwd.value;
        end
        return rf_val;
    endfunction

    assign id_allowin_o = ~id_valid_q | ex_allowin_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_valid_q <= 1'b0;
        end else if (flush_i) begin
            id_valid_q <= 1'b0;
        end else if (id_allowin_o) begin
            id_valid_q <= if_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (if_valid_i && id_allowin_o) begin
            id_q <= if_to_id_i;
        end
    end

    assign inst = id_q.inst;
    assign rd   = inst[4:0];

    always_comb begin
        alu_op  = ALU_NONE;
        imm     = '0;
        use_imm = 1'b0;
        is_bne  = 1'b0;
        case (op17_e'(inst[31:15]))
            OP17_ADD_W: alu_op = ALU_ADD;
            OP17_SUB_W: alu_op = ALU_SUB;
            OP17_AND:   alu_op = ALU_AND;
            OP17_OR:    alu_op = ALU_OR;
            OP17_XOR:   alu_op = ALU_XOR;
            default:    ;
        endcase
        if (op10_e'(inst[31:22]) == OP10_ADDI_W) begin
            alu_op  = ALU_ADD;
            imm     = {{20{inst[21]}}, inst[21:10]};
            use_imm = 1'b1;
        end
        if (op7_e'(inst[31:25]) == OP7_LU12I_W) begin
            alu_op  = ALU_LUI;
            imm     = {inst[24:5], 12'b0};
            use_imm = 1'b1;
        end
        if (op6_e'(inst[31:26]) == OP6_BNE) begin
            is_bne = 1'b1;
        end
    end

    // bne compares rj against rd
    assign rj_addr_o = inst[9:5];
    assign rk_addr_o = is_bne ? rd : inst[14:10];
    assign rj_val    = pick_src(rj_addr_o, rj_data_i, ex_fwd_i, wb_fwd_i);
    assign rk_val    = pick_src(rk_addr_o, rk_data_i, ex_fwd_i, wb_fwd_i);

    assign id_valid_o = id_valid_q & ~flush_i;
    assign id_to_ex_o = '{
        pc:      id_q.pc,
        alu_op:  alu_op,
        src_a:   rj_val,
        src_b:   use_imm ? imm : rk_val,
        rd:      rd,
        rf_we:   (alu_op != ALU_NONE) && (rd != '0),
        is_bne:  is_bne,
        rj_val:  rj_val,
        rd_val:  rk_val,
        br_offs: inst[25:10]
    };

endmodule

// ==== design/fetch_stage.sv ====
// ======================================================================
// fetch stage: pc sequencing, inst SRAM req/response, branch redirect
// ======================================================================
`timescale 1ns/10ps

module fetch_stage import la32_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = la32_pkg::RESET_PC
) (
    input  logic            clk,
    input  logic            rst_n_i,
    output logic            inst_sram_req_o,
    output logic [XLEN-1:0] inst_sram_addr_o,
    input  logic            inst_sram_addr_ok_i,
    input  logic            inst_sram_data_ok_i,
    input  logic [XLEN-1:0] inst_sram_rdata_i,
    input  logic            id_allowin_i,
    input  redirect_t       redirect_i,
    output logic            if_valid_o,
    output if_to_id_t       if_to_id_o
);

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] inflight_pc_q;
    logic [XLEN-1:0] redir_tgt_q;
    logic            pending_q;
    logic            discard_q;
    logic            redir_pend_q;
    logic            buf_valid_q;
    if_to_id_t       buf_q;
    logic            accept;
    logic            resp_ok;
    logic            buf_free;

    // buffer drains this cycle or is already empty
    assign buf_free = ~buf_valid_q | id_allowin_i;

    // one request in flight, the next may go out with data_ok
    assign inst_sram_req_o  = (~pending_q | inst_sram_data_ok_i) & buf_free;
    assign inst_sram_addr_o = pc_q;
    assign accept           = inst_sram_req_o & inst_sram_addr_ok_i;
    assign resp_ok          = inst_sram_data_ok_i & ~discard_q & ~redirect_i.taken;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q         <= RESET_PC;
            pending_q    <= 1'b0;
            discard_q    <= 1'b0;
            redir_pend_q <= 1'b0;
            buf_valid_q  <= 1'b0;
        end else begin
            if (accept) begin
                // an accepted request still belongs to the old path
                discard_q <= redirect_i.taken | redir_pend_q;
                pc_q      <= redirect_i.taken ? redirect_i.target :
                             redir_pend_q     ? redir_tgt_q       : pc_q + 32'd4;
            end else if (redirect_i.taken) begin
                if (!inst_sram_req_o) begin
                    pc_q <= redirect_i.target;
                end
                if (pending_q && !inst_sram_data_ok_i) begin
                    discard_q <= 1'b1;
                end
            end else if (inst_sram_data_ok_i) begin
                discard_q <= 1'b0;
            end

            // address must hold while a request waits for addr_ok
            if (accept) begin
                redir_pend_q <= 1'b0;
            end else if (redirect_i.taken && inst_sram_req_o) begin
                redir_pend_q <= 1'b1;
            end

            if (accept) begin
                pending_q <= 1'b1;
            end else if (inst_sram_data_ok_i) begin
                pending_q <= 1'b0;
            end

            if (redirect_i.taken) begin
                buf_valid_q <= 1'b0;
            end else if (resp_ok) begin
                buf_valid_q <= 1'b1;
            end else if (id_allowin_i) begin
                buf_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            inflight_pc_q <= pc_q;
        end
        if (redirect_i.taken && inst_sram_req_o && !accept) begin
            redir_tgt_q <= redirect_i.target;
        end
        if (resp_ok) begin
            buf_q <= '{pc: inflight_pc_q, inst: inst_sram_rdata_i};
        end
    end

    assign if_valid_o = buf_valid_q;
    assign if_to_id_o = buf_q;

    a_no_orphan_data_ok: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        inst_sram_data_ok_i |-> pending_q
    );

endmodule

// ==== design/la32_pkg.sv ====
// ======================================================================
// la32 shared definitions: widths, opcode encodings, stage payloads
// ======================================================================
package la32_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC = 32'h1c00_0000;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_LUI,
        ALU_NONE
    } alu_op_e;

    // three-register format, inst[31:15]
    typedef enum logic [16:0] {
        OP17_ADD_W = 17'h00020,
        OP17_SUB_W = 17'h00022,
        OP17_AND   = 17'h00029,
        OP17_OR    = 17'h0002a,
        OP17_XOR   = 17'h0002b
    } op17_e;

    // si12 format, inst[31:22]
    typedef enum logic [9:0] {
        OP10_ADDI_W = 10'h00a
    } op10_e;

    // si20 format, inst[31:25]
    typedef enum logic [6:0] {
        OP7_LU12I_W = 7'h0a
    } op7_e;

    // offs16 branch format, inst[31:26]
    typedef enum logic [5:0] {
        OP6_BNE = 6'h17
    } op6_e;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
    } if_to_id_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        alu_op_e               alu_op;
        logic [XLEN-1:0]       src_a;
        logic [XLEN-1:0]       src_b;
        logic [REG_ADDR_W-1:0] rd;
        logic                  rf_we;
        logic                  is_bne;
        logic [XLEN-1:0]       rj_val;
        logic [XLEN-1:0]       rd_val;
        logic [15:0]           br_offs;
    } id_to_ex_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic                  rf_we;
        logic [XLEN-1:0]       result;
    } ex_to_wb_t;

    typedef struct packed {
        logic                  valid;
        logic                  rf_we;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       value;
    } fwd_t;

    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
    } wb_write_t;

endpackage
